//--- tenyr_cfg.svh
`ifndef TENYR_CFG_SVH
`define TENYR_CFG_SVH

// Size of the block RAM in 32-bit words.
// The RAM region on the data bus runs from address 0 up to this value.
`define RAM_WORDS 1024

// Word addresses of the memory-mapped devices.
// They sit inside the RAM range, and the top level gives them priority.
`define SEG7_ADDR 32'h100
`define LED_ADDR 32'h101
`define SEGMASK_ADDR 32'h102

// Clock cycles that each display digit stays lit.
// Any value of 2 or more works, and a small one keeps simulation short.
`define SEG7_SCAN_DIV 4

`endif

//--- tenyr_pkg.sv
package tenyr_pkg;

    // One bus word, seen either as a plain word or as eight hex nibbles.
    typedef union packed {
        logic [31:0]      raw;
        logic [7:0][3:0]  nib;
    } bus_word_t;

    // Active-low segment drive, bit 7 is the decimal point, bits 6..0 are g..a.
    typedef logic [7:0] seg_pattern_t;

    localparam seg_pattern_t SEG_BLANK = 8'hFF;

    // Standard hex glyphs. The decimal point is always off.
    function automatic seg_pattern_t hex_to_seg(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        // Segments are active low on the board.
        return {1'b1, ~lit};
    endfunction

endpackage

//--- block_mem.sv
`include "tenyr_cfg.svh"

module block_mem (
    input  logic                 clk,
    input  logic                 en,
    input  logic                 we,
    input  logic [9:0]           addr_a,
    input  tenyr_pkg::bus_word_t din_a,
    output tenyr_pkg::bus_word_t dout_a,
    input  logic [9:0]           addr_b,
    output tenyr_pkg::bus_word_t dout_b
);

    tenyr_pkg::bus_word_t mem [`RAM_WORDS];

    // Port a serves the data bus.
    // A write cycle leaves dout_a alone, so the last read result stays on it.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr_a] <= din_a;
            end else begin
                dout_a <= mem[addr_a];
            end
        end
    end

    // Port b is the instruction fetch path and never writes.
    always_ff @(posedge clk) begin
        dout_b <= mem[addr_b];
    end

    // An enabled cycle with an unknown direction or address would corrupt
    // a word or read back garbage.
    a_known_access: assert property (
        @(posedge clk) en |-> !$isunknown({we, addr_a})
    ) else $error("block_mem: port a enabled with an unknown address or direction");

endmodule

//--- mmr.sv
module mmr #(
    parameter logic [31:0]      ADDR    = 32'h0,
    parameter int               WIDTH   = 32,
    parameter logic [WIDTH-1:0] DEFAULT = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             rw,
    input  logic [31:0]      addr,
    input  logic [31:0]      wdata,
    output logic [31:0]      rdata,
    output logic             hit,
    output logic [WIDTH-1:0] val
);

    logic match;

    assign match = (addr == ADDR);

    // The hit flag only moves on read cycles.
    // That keeps a read result on the bus until the next read.
    always_ff @(posedge clk) begin
        if (reset) begin
            val <= DEFAULT;
            hit <= 1'b0;
        end else if (rw) begin
            if (match) begin
                val <= wdata[WIDTH-1:0];
            end
        end else begin
            hit <= match;
        end
    end

    // Readback is zero extended to the full bus width.
    always_ff @(posedge clk) begin
        if (!rw && match) begin
            rdata <= 32'(val);
        end
    end

    a_rw_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(rw)
    ) else $error("mmr: rw is unknown on the data bus");

endmodule

//--- seg7_display.sv
`include "tenyr_cfg.svh"

module seg7_display #(
    parameter logic [31:0] BASE = `SEG7_ADDR
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rw,
    input  logic [31:0]             addr,
    input  logic [31:0]             wdata,
    output logic [31:0]             rdata,
    output logic                    hit,
    input  logic [3:0]              mask,
    output tenyr_pkg::seg_pattern_t seg,
    output logic [3:0]              an
);

    localparam int SCAN_W = $clog2(`SEG7_SCAN_DIV);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`SEG7_SCAN_DIV - 1);

    tenyr_pkg::bus_word_t    value;
    tenyr_pkg::seg_pattern_t glyph;
    logic [SCAN_W-1:0]       scan_cnt;
    logic [1:0]              digit;
    logic                    running;
    logic                    match;

    assign match = (addr == BASE);

    // The bus writes the word as a whole, the scan reads it nibble by nibble.
    assign glyph = tenyr_pkg::hex_to_seg(value.nib[{1'b0, digit}]);

    // Display value register. Only 16 bits are kept, the rest reads as zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            value.raw <= '0;
            hit       <= 1'b0;
        end else if (rw) begin
            if (match) begin
                value.raw <= {16'h0000, wdata[15:0]};
            end
        end else begin
            hit <= match;
        end
    end

    always_ff @(posedge clk) begin
        if (!rw && match) begin
            rdata <= value.raw;
        end
    end

    // Scan timing.
    // The first lap of the counter after reset keeps the display dark.
    // After that, every lap moves the pointer on by one digit.
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt <= '0;
            digit    <= 2'd0;
            running  <= 1'b0;
        end else if (scan_cnt == SCAN_LAST) begin
            scan_cnt <= '0;
            running  <= 1'b1;
            if (running) begin
                digit <= digit + 2'd1;
            end
        end else begin
            scan_cnt <= scan_cnt + SCAN_W'(1);
        end
    end

    // Registered pin drive. A masked digit keeps its anode low but shows
    // nothing, so the brightness of the others does not change.
    always_ff @(posedge clk) begin
        if (reset || !running) begin
            an  <= 4'hF;
            seg <= tenyr_pkg::SEG_BLANK;
        end else begin
            an <= ~(4'b0001 << digit);
            if (mask[digit]) begin
                seg <= glyph;
            end else begin
                seg <= tenyr_pkg::SEG_BLANK;
            end
        end
    end

    // Each digit stays lit for a whole scan step. The anodes follow the
    // pointer one cycle late, so a change is seen with the counter at one.
    a_anode_step: assert property (
        @(posedge clk) disable iff (reset)
            (running && $changed(an)) |-> (scan_cnt == SCAN_W'(1))
    ) else $error("seg7_display: anodes moved inside a scan step");

endmodule

//--- tenyr_soc.sv
`include "tenyr_cfg.svh"

module tenyr_soc (
    input  logic        clk,
    input  logic        reset,
    input  logic        rw,
    input  logic [31:0] d_addr,
    input  logic [31:0] d_wdata,
    output logic [31:0] d_rdata,
    input  logic [31:0] i_addr,
    output logic [31:0] i_data,
    output logic [7:0]  led,
    output logic [7:0]  seg,
    output logic [3:0]  an
);

    tenyr_pkg::bus_word_t ram_wdata;
    tenyr_pkg::bus_word_t ram_rdata;
    tenyr_pkg::bus_word_t ram_idata;

    logic        dev_hit;
    logic        ram_hit;
    logic        ram_rd_hit;
    logic        i_hit;
    logic [31:0] led_rdata;
    logic [31:0] segmask_rdata;
    logic [31:0] seg7_rdata;
    logic        led_hit;
    logic        segmask_hit;
    logic        seg7_hit;
    logic [3:0]  seg_mask;

    // The device words sit inside the RAM range and take priority over it.
    assign dev_hit   = d_addr inside {`SEG7_ADDR, `LED_ADDR, `SEGMASK_ADDR};
    assign ram_hit   = (d_addr < 32'(`RAM_WORDS)) && !dev_hit;
    assign ram_wdata = d_wdata;

    block_mem ram (
        .clk    (clk),
        .en     (ram_hit),
        .we     (rw),
        .addr_a (d_addr[9:0]),
        .din_a  (ram_wdata),
        .dout_a (ram_rdata),
        .addr_b (i_addr[9:0]),
        .dout_b (ram_idata)
    );

    mmr #(.ADDR(`LED_ADDR), .WIDTH(8), .DEFAULT(8'h00)) led_reg (
        .clk   (clk),
        .reset (reset),
        .rw    (rw),
        .addr  (d_addr),
        .wdata (d_wdata),
        .rdata (led_rdata),
        .hit   (led_hit),
        .val   (led)
    );

    mmr #(.ADDR(`SEGMASK_ADDR), .WIDTH(4), .DEFAULT(4'hF)) segmask_reg (
        .clk   (clk),
        .reset (reset),
        .rw    (rw),
        .addr  (d_addr),
        .wdata (d_wdata),
        .rdata (segmask_rdata),
        .hit   (segmask_hit),
        .val   (seg_mask)
    );

    seg7_display #(.BASE(`SEG7_ADDR)) seg7 (
        .clk   (clk),
        .reset (reset),
        .rw    (rw),
        .addr  (d_addr),
        .wdata (d_wdata),
        .rdata (seg7_rdata),
        .hit   (seg7_hit),
        .mask  (seg_mask),
        .seg   (seg),
        .an    (an)
    );

    // RAM read flag, updated on read cycles like the device flags.
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_rd_hit <= 1'b0;
        end else if (!rw) begin
            ram_rd_hit <= ram_hit;
        end
    end

    // Fetches beyond the RAM return zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            i_hit <= 1'b0;
        end else begin
            i_hit <= (i_addr < 32'(`RAM_WORDS));
        end
    end

    assign i_data = {32{i_hit}} & ram_idata.raw;

    // Only the block that matched the last read has its flag set,
    // so a miss on every region leaves zero on the bus.
    assign d_rdata = ({32{ram_rd_hit}}  & ram_rdata.raw)
                   | ({32{led_hit}}     & led_rdata)
                   | ({32{segmask_hit}} & segmask_rdata)
                   | ({32{seg7_hit}}    & seg7_rdata);

    a_single_source: assert property (
        @(posedge clk) disable iff (reset)
            $onehot0({ram_rd_hit, led_hit, segmask_hit, seg7_hit})
    ) else $error("tenyr_soc: more than one block drives read data");

endmodule

//--- tb_tenyr_soc.sv
`include "tenyr_cfg.svh"

module tb_tenyr_soc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          RANDOM_WORDS = 8;
    localparam logic [31:0] IDLE_ADDR    = 32'hFFFF_FFF0;

    logic        clk;
    logic        reset;
    logic        rw;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic [31:0] d_rdata;
    logic [31:0] i_addr;
    logic [31:0] i_data;
    logic [7:0]  led;
    logic [7:0]  seg;
    logic [3:0]  an;

    byte         case_op [$];
    logic [31:0] case_addr [$];
    logic [31:0] case_data [$];
    logic [31:0] case_exp [$];
    int          n_cases = 0;
    int          error_count = 0;
    logic [7:0]  led_model;

    tenyr_soc i_dut (
        .clk     (clk),
        .reset   (reset),
        .rw      (rw),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .led     (led),
        .seg     (seg),
        .an      (an)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Each case gets a budget of two full display scans.
    initial begin
        wait (n_cases > 0);
        repeat ((n_cases + 8) * 8 * `SEG7_SCAN_DIV) @(posedge clk);
        $display("Watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    // Active-low hex glyphs, decimal point off.
    function automatic logic [7:0] expected_glyph(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic load_cases();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("tenyr_cases.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open tenyr_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0 && line.len() > 1 && line[0] != "#") begin
                rc = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, e);
                if (rc == 3) begin
                    case_op.push_back(line[0]);
                    case_addr.push_back(a);
                    case_data.push_back(d);
                    case_exp.push_back(e);
                end else begin
                    error_count++;
                    $display("Malformed case line: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // The LED latch is checked after every write, so a stray store shows up here.
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        rw      <= 1'b1;
        d_addr  <= addr;
        d_wdata <= data;
        @(posedge clk);
        rw     <= 1'b0;
        d_addr <= IDLE_ADDR;
        if (addr == `LED_ADDR) begin
            led_model = data[7:0];
        end
        @(negedge clk);
        if (led !== led_model) begin
            report_mismatch("led", 32'(led), 32'(led_model));
        end
    endtask

    task automatic bus_read_check(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk);
        rw     <= 1'b0;
        d_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        if (d_rdata !== exp) begin
            report_mismatch("d_rdata", d_rdata, exp);
        end
    endtask

    task automatic fetch_check(input logic [31:0] addr, input logic [31:0] exp);
        @(posedge clk);
        i_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        if (i_data !== exp) begin
            report_mismatch("i_data", i_data, exp);
        end
    endtask

    // Follows digits 0 to 3 in turn and checks each glyph while its anode is low.
    task automatic scan_check(input logic [15:0] value, input logic [3:0] mask);
        logic [7:0] want;
        logic [3:0] want_an;
        int         k;
        int         waited;
        @(posedge clk);
        for (k = 0; k < 4; k++) begin
            want_an = ~(4'b0001 << k);
            waited  = 0;
            @(negedge clk);
            while (an !== want_an && waited < 6 * `SEG7_SCAN_DIV) begin
                @(negedge clk);
                waited++;
            end
            if (an !== want_an) begin
                error_count++;
                $display("Anode of digit %0d never went low at %0d ns", k, $time);
            end else begin
                want = mask[k] ? expected_glyph(value[4*k +: 4]) : 8'hFF;
                if (seg !== want) begin
                    report_mismatch($sformatf("seg digit %0d", k), 32'(seg), 32'(want));
                end
            end
        end
    endtask

    // Addresses are 37 apart with a jitter under 30, so no two of them collide.
    task automatic random_ram_test();
        logic [31:0] addrs [RANDOM_WORDS];
        logic [31:0] words [RANDOM_WORDS];
        int          i;
        for (i = 0; i < RANDOM_WORDS; i++) begin
            addrs[i] = 32'h200 + 32'(i * 37) + ($urandom % 30);
            words[i] = $urandom;
            bus_write(addrs[i], words[i]);
        end
        for (i = 0; i < RANDOM_WORDS; i++) begin
            bus_read_check(addrs[i], words[i]);
        end
    endtask

    initial begin
        int seed_val;
        int idx;
        reset     = 1'b1;
        rw        = 1'b0;
        d_addr    = IDLE_ADDR;
        d_wdata   = '0;
        i_addr    = '0;
        led_model = 8'h00;
        seed_val  = $urandom(32'h26ce_cbb3);
        load_cases();
        n_cases = case_op.size();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (led !== 8'h00) begin
            report_mismatch("led", 32'(led), 32'h0);
        end
        if (d_rdata !== 32'h0) begin
            report_mismatch("d_rdata", d_rdata, 32'h0);
        end
        if (an !== 4'hF) begin
            report_mismatch("an", 32'(an), 32'hF);
        end
        if (seg !== 8'hFF) begin
            report_mismatch("seg", 32'(seg), 32'hFF);
        end
        for (idx = 0; idx < n_cases; idx++) begin
            case (case_op[idx])
                "W": bus_write(case_addr[idx], case_data[idx]);
                "R": bus_read_check(case_addr[idx], case_exp[idx]);
                "I": fetch_check(case_addr[idx], case_exp[idx]);
                "S": scan_check(case_addr[idx][15:0], case_data[idx][3:0]);
                default: begin
                    error_count++;
                    $display("Unknown operation in case %0d", idx);
                end
            endcase
        end
        random_ram_test();
        $display("Ran %0d cases and %0d random words, %0d errors",
                 n_cases, RANDOM_WORDS, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tenyr_cases.txt
# Columns: op addr data expected, all in hex. Ops: W write, R data read, I fetch.
# S checks the display scan, with the 16-bit value in addr and the digit mask in data.
W 00000000 11111111 00000000
W 00000010 deadbeef 00000000
R 00000010 00000000 deadbeef
W 00000011 12345678 00000000
R 00000011 00000000 12345678
W 000003ff a5a5a5a5 00000000
R 000003ff 00000000 a5a5a5a5
I 00000010 00000000 deadbeef
I 000003ff 00000000 a5a5a5a5
W 00000020 0badf00d 00000000
I 00000020 00000000 0badf00d
R 00000400 00000000 00000000
W 00000400 ffffffff 00000000
R 00000400 00000000 00000000
R 00000000 00000000 11111111
R 00000101 00000000 00000000
R 00000102 00000000 0000000f
W 00000101 1234abcd 00000000
R 00000101 00000000 000000cd
W 00000100 ffff1234 00000000
R 00000100 00000000 00001234
S 00001234 0000000f 00000000
W 00000100 0000beef 00000000
S 0000beef 0000000f 00000000
W 00000102 00000005 00000000
R 00000102 00000000 00000005
S 0000beef 00000005 00000000
W 00000102 0000000a 00000000
S 0000beef 0000000a 00000000
W 80000000 00000077 00000000
R 00000101 00000000 000000cd
R 00000100 00000000 0000beef
R 00000102 00000000 0000000a

//--- files.f
+incdir+.
tenyr_pkg.sv
block_mem.sv
mmr.sv
seg7_display.sv
tenyr_soc.sv
tb_tenyr_soc.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_tenyr_soc
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# The run fails if the simulator exits with an error or the log holds the fail message.
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
